// ==== compile.f ====
+incdir+hdl
hdl/heapPkg.sv
hdl/storeBus.sv
hdl/heapControl.sv
hdl/scanCounter.sv
hdl/arrayStore.sv
hdl/arrayAllocator.sv
hdl/elementAlu.sv
hdl/heapMemory.sv
bench/heapMemoryTb.sv

// ==== Bender.yml ====
package:
  name: heap_memory

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/heapPkg.sv
      - hdl/storeBus.sv
      - hdl/heapControl.sv
      - hdl/scanCounter.sv
      - hdl/arrayStore.sv
      - hdl/arrayAllocator.sv
      - hdl/elementAlu.sv
      - hdl/heapMemory.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/heapMemoryTb.sv

// ==== bench/heapMemoryTb.sv ====
//--------------------------------------
// Heap memory testbench
// Directed requests checked against a behavioral heap model
//--------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module heapMemoryTb import heapPkg::*; ();

  localparam int CYCLE_LIMIT = 3000;               // About four times the directed sequence

  logic        clock;
  logic        resetN;
  logic        start;
  heapAction_t action;
  arrayId_t    arrayId;
  index_t      index;
  data_t       operand;
  logic        done;
  data_t       result;
  heapError_t  error;

  int    errorCount = 0;
  int    cycleCount = 0;
  int    latency;                                  // Cycles from start to done
  data_t lastResult;

  // Behavioral heap
  int       mark;
  logic     modelAlloc [`HEAP_ARRAYS];
  int       modelSize  [`HEAP_ARRAYS];
  data_t    modelMem   [`HEAP_ARRAYS][`HEAP_LENGTH];
  arrayId_t freeStack  [$];                        // LIFO of freed arrays

  heapMemory heapMemory_inst (
    .clock, .resetN, .start, .action, .arrayId, .index, .operand,
    .done, .result, .error
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing, %0d errors so far",
               cycleCount, errorCount);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //--------------------------------------
  // Model
  //--------------------------------------
  function automatic logic isElementOp(heapAction_t act);
    return act inside {actAdd, actAddAfter, actSub, actSubAfter, actShiftLeft,
                       actShiftRight, actNotLogical, actNot, actOr, actXor, actAnd};
  endfunction

  function automatic data_t applyOp(heapAction_t act, data_t value, data_t opnd);
    case (act)
      actAdd, actAddAfter: return value + opnd;
      actSub, actSubAfter: return value - opnd;
      actShiftLeft:        return value << opnd;
      actShiftRight:       return value >> opnd;
      actNotLogical:       return (value == '0) ? data_t'(1) : data_t'(0);
      actNot:              return ~value;
      actOr:               return value | opnd;
      actXor:              return value ^ opnd;
      default:             return value & opnd;
    endcase
  endfunction

  task automatic modelAction(input heapAction_t act, input arrayId_t id, input index_t idx,
                             input data_t opnd, output data_t res, output heapError_t err,
                             output int cycles);
    int       size;
    arrayId_t newId;
    data_t    oldValue;
    size   = modelSize[id];
    res    = '0;
    err    = errNone;
    cycles = 2;
    // Never allocated, then freed, then bounds or capacity
    if (act == actAlloc) begin
      if (freeStack.size() == 0 && mark == `HEAP_ARRAYS) err = errOutOfMemory;
    end else if (act != actReset) begin
      if (id >= mark) err = errNotAllocated;
      else if (!modelAlloc[id]) err = (act == actFree) ? errDoubleFree : errFreed;
      else if (act inside {actInc, actPush} && size == `HEAP_LENGTH) err = errFull;
      else if (act inside {actDec, actPop} && size == 0) err = errEmpty;
      else if (act == actResize && opnd > `HEAP_LENGTH) err = errTooLarge;
      else if ((act == actRead || isElementOp(act)) && idx >= size) err = errBounds;
    end
    if (err == errNone) begin
      case (act)
        actReset: begin
          mark = 0;
          freeStack.delete();
          foreach (modelAlloc[i]) modelAlloc[i] = 1'b0;
        end
        actWrite: begin
          modelMem[id][idx] = opnd;
          if (idx >= size) modelSize[id] = int'(idx) + 1;  // Grows to cover the index
          res = opnd;
        end
        actRead: res = modelMem[id][idx];
        actSize: res = data_t'(size);
        actInc, actDec: begin
          modelSize[id] = (act == actInc) ? size + 1 : size - 1;
          res = data_t'(modelSize[id]);
        end
        actPush: begin
          modelMem[id][size] = opnd;
          modelSize[id] = size + 1;
          res = opnd;
        end
        actPop: begin
          res = modelMem[id][size - 1];
          modelSize[id] = size - 1;
        end
        actResize: begin
          modelSize[id] = int'(opnd);
          res = opnd;
        end
        actAlloc: begin
          if (freeStack.size() > 0) begin
            newId = freeStack.pop_back();          // Freed arrays come back first
          end else begin
            newId = arrayId_t'(mark);
            mark++;
          end
          modelAlloc[newId] = 1'b1;
          modelSize[newId]  = 0;
          res = data_t'(newId);
        end
        actFree: begin
          modelAlloc[id] = 1'b0;
          freeStack.push_back(id);
          res = data_t'(id);
        end
        actIndex, actLess, actGreater: begin
          cycles = 2 + size;                       // One cycle per element
          for (int i = 0; i < size; i++) begin
            if (act == actIndex && modelMem[id][i] == opnd) res = data_t'(i + 1);
            if (act == actLess && modelMem[id][i] < opnd) res++;
            if (act == actGreater && modelMem[id][i] > opnd) res++;
          end
        end
        default: begin
          oldValue = modelMem[id][idx];
          modelMem[id][idx] = applyOp(act, oldValue, opnd);
          res = (act inside {actAddAfter, actSubAfter}) ? oldValue : modelMem[id][idx];
        end
      endcase
    end
  endtask

  //--------------------------------------
  // Request and check
  //--------------------------------------
  task automatic checkValue(input string name, input data_t got, input data_t expected);
    assert (got === expected) else begin
      errorCount++;
      $display("FAIL %s after %s: got %h, expected %h", name, action.name(), got, expected);
    end
  endtask

  task automatic sendRequest(input heapAction_t act, input arrayId_t id, input index_t idx,
                             input data_t opnd);
    @(posedge clock);
    #1;
    start   = 1'b1;
    action  = act;
    arrayId = id;
    index   = idx;
    operand = opnd;
    @(posedge clock);
    #1;
    start   = 1'b0;
    latency = 1;
    while (!done) begin                            // Fields hold until the next edge
      @(posedge clock);
      #1;
      latency++;
    end
  endtask

  task automatic runAction(input heapAction_t act, input arrayId_t id, input index_t idx,
                           input data_t opnd);
    data_t      expResult;
    heapError_t expError;
    int         expCycles;
    modelAction(act, id, idx, opnd, expResult, expError, expCycles);
    sendRequest(act, id, idx, opnd);
    lastResult = result;
    checkValue("error", data_t'(error), data_t'(expError));
    if (expError == errNone) checkValue("result", result, expResult);
    checkValue("latency", data_t'(latency), data_t'(expCycles));
  endtask

  //--------------------------------------
  // Directed tests
  //--------------------------------------
  task automatic testAllocation();
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin
      runAction(actAlloc, '0, '0, '0);
      checkValue("allocated array", lastResult, data_t'(i));
    end
    runAction(actAlloc, '0, '0, '0);               // All arrays held
    runAction(actFree, 3'd5, '0, '0);
    runAction(actFree, 3'd2, '0, '0);
    runAction(actAlloc, '0, '0, '0);
    checkValue("allocated array", lastResult, data_t'(2));
    runAction(actAlloc, '0, '0, '0);
    checkValue("allocated array", lastResult, data_t'(5));
    runAction(actFree, 3'd6, '0, '0);
    runAction(actFree, 3'd6, '0, '0);              // Second free of the same array
    runAction(actReset, '0, '0, '0);
    runAction(actAlloc, '0, '0, '0);
    checkValue("allocated array", lastResult, data_t'(0));
  endtask

  task automatic testAccess();
    data_t value;
    value = data_t'($urandom);
    runAction(actWrite, 3'd0, 3'd0, value);
    runAction(actRead, 3'd0, 3'd0, '0);
    checkValue("read data", lastResult, value);
    runAction(actRead, 3'd0, 3'd1, '0);            // At the size
    runAction(actRead, 3'd0, 3'd6, '0);
    runAction(actWrite, 3'd4, 3'd0, value);        // Above the high-water mark
    runAction(actAlloc, '0, '0, '0);
    runAction(actFree, 3'd1, '0, '0);
    runAction(actRead, 3'd1, 3'd0, '0);
    runAction(actWrite, 3'd1, 3'd0, value);
    runAction(actAlloc, '0, '0, '0);
    runAction(actWrite, 3'd1, 3'd4, value + data_t'(1));
    runAction(actSize, 3'd1, '0, '0);
    checkValue("size", lastResult, data_t'(5));
  endtask

  task automatic testSizeChanges();
    arrayId_t id;
    data_t    pushed [$];
    runAction(actAlloc, '0, '0, '0);
    id = arrayId_t'(lastResult);
    for (int i = 0; i <= `HEAP_LENGTH; i++) begin
      pushed.push_back(data_t'($urandom));
      runAction(actPush, id, '0, pushed[i]);       // Last one finds the array full
    end
    for (int i = 0; i <= `HEAP_LENGTH; i++) begin
      runAction(actPop, id, '0, '0);
      if (i < `HEAP_LENGTH) checkValue("popped value", lastResult, pushed[`HEAP_LENGTH - 1 - i]);
    end
    for (int i = 0; i <= `HEAP_LENGTH; i++) runAction(actInc, id, '0, '0);
    for (int i = 0; i <= `HEAP_LENGTH; i++) runAction(actDec, id, '0, '0);
    runAction(actResize, id, '0, data_t'(`HEAP_LENGTH + 1));
    runAction(actResize, id, '0, data_t'(3));
    runAction(actSize, id, '0, '0);
  endtask

  task automatic testElementOps();
    heapAction_t ops [11];
    arrayId_t    id;
    index_t      idx;
    data_t       opnd;
    ops = '{actAdd, actAddAfter, actSub, actSubAfter, actShiftLeft, actShiftRight,
            actNotLogical, actNot, actOr, actXor, actAnd};
    runAction(actAlloc, '0, '0, '0);
    id = arrayId_t'(lastResult);
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      runAction(actWrite, id, index_t'(i), data_t'($urandom));
    end
    for (int round = 0; round < 3; round++) begin
      foreach (ops[k]) begin
        idx  = index_t'($urandom_range(`HEAP_LENGTH - 1, 0));
        opnd = (ops[k] inside {actShiftLeft, actShiftRight}) ? data_t'($urandom_range(17, 0))
                                                             : data_t'($urandom);
        runAction(ops[k], id, idx, opnd);
        runAction(actRead, id, idx, '0);           // Value left in place
      end
    end
    runAction(actResize, id, '0, data_t'(4));
    runAction(actAdd, id, 3'd6, data_t'(1));       // Past the new size
  endtask

  task automatic testScans();
    arrayId_t id;
    int       lengths [3];
    data_t    probe;
    lengths = '{0, 5, 8};
    runAction(actAlloc, '0, '0, '0);
    id = arrayId_t'(lastResult);
    // Small values so searches hit and counts vary
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      runAction(actWrite, id, index_t'(i), data_t'($urandom_range(7, 0)));
    end
    foreach (lengths[k]) begin
      runAction(actResize, id, '0, data_t'(lengths[k]));
      probe = data_t'($urandom_range(7, 0));
      runAction(actLess, id, '0, probe);
      runAction(actGreater, id, '0, probe);
      runAction(actIndex, id, '0, probe);
      runAction(actIndex, id, '0, data_t'(100));   // Matches nothing
    end
  endtask

  initial begin
    int seedValue;
    seedValue = $urandom(21516);
    resetN  = 1'b0;
    start   = 1'b0;
    action  = actReset;
    arrayId = '0;
    index   = '0;
    operand = '0;
    mark    = 0;
    foreach (modelAlloc[i]) begin
      modelAlloc[i] = 1'b0;
      modelSize[i]  = 0;
    end
    repeat (4) @(posedge clock);
    #1;
    resetN = 1'b1;
    assert (done === 1'b0) else begin
      errorCount++;
      $display("Done is not low after reset");
    end
    testAllocation();
    testAccess();
    testSizeChanges();
    testElementOps();
    testScans();
    $display("Finished after %0d cycles with %0d errors", cycleCount, errorCount);
    if (errorCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/heapMemory.sv ====
//--------------------------------------
// Heap memory top
// Fixed-size arrays with allocate, free and element actions
//--------------------------------------
`timescale 1ns/100ps

module heapMemory import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        start,                       // One-cycle request strobe
  input  heapAction_t action,
  input  arrayId_t    arrayId,
  input  index_t      index,
  input  data_t       operand,
  output logic        done,
  output data_t       result,
  output heapError_t  error
);

  logic     allocate, releaseArray;
  arrayId_t granted;
  logic     allocated, known, full, stackHit;
  logic     scanStart, scanLast;
  size_t    limit;
  index_t   scanIndex;
  aluOp_t   op;
  data_t    element, aluOperand, newValue;

  storeBus storeIf ();

  heapControl heapControl_inst (
    .clock, .resetN, .start, .action, .arrayId, .index, .operand,
    .done, .result, .error,
    .allocate, .releaseArray, .granted, .allocated, .known, .full, .stackHit,
    .scanStart, .limit, .scanIndex, .scanLast,
    .op, .element, .operandOut(aluOperand), .newValue,
    .store(storeIf)
  );

  scanCounter scanCounter_inst (
    .clock, .resetN, .scanStart, .limit, .scanIndex, .scanLast
  );

  arrayStore arrayStore_inst (
    .clock, .resetN, .store(storeIf)
  );

  // Allocator sees the array addressed on the storage bus
  arrayAllocator arrayAllocator_inst (
    .clock, .resetN, .allocate, .releaseArray, .arrayId(storeIf.arrayId),
    .granted, .allocated, .known, .full, .stackHit
  );

  elementAlu elementAlu_inst (
    .op, .element, .operand(aluOperand), .newValue
  );

endmodule

// ==== hdl/elementAlu.sv ====
//--------------------------------------
// Element ALU
// In-place arithmetic, logic and compare
//--------------------------------------
`timescale 1ns/100ps

module elementAlu import heapPkg::*; (
  input  aluOp_t op,
  input  data_t  element,                          // Current array element
  input  data_t  operand,
  output data_t  newValue
);

  always_comb begin
    case (op)
      aluAdd:        newValue = element + operand;
      aluSub:        newValue = element - operand;
      aluShl:        newValue = element << operand;
      aluShr:        newValue = element >> operand;
      aluNotLogical: newValue = data_t'(element == '0);
      aluNot:        newValue = ~element;
      aluOr:         newValue = element | operand;
      aluXor:        newValue = element ^ operand;
      aluAnd:        newValue = element & operand;
      // Scan comparisons return the match in bit 0
      aluEqual:      newValue = data_t'(element == operand);
      aluLess:       newValue = data_t'(element < operand);
      aluGreater:    newValue = data_t'(element > operand);
      default:       newValue = operand;           // Plain store
    endcase
  end

endmodule

// ==== hdl/arrayAllocator.sv ====
//--------------------------------------
// Array allocator
// Allocation bits, high-water mark and freed-array stack
//--------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module arrayAllocator import heapPkg::*; (
  input  logic     clock,
  input  logic     resetN,
  input  logic     allocate,
  input  logic     releaseArray,
  input  arrayId_t arrayId,
  output arrayId_t granted,                        // Next array handed out
  output logic     allocated,
  output logic     known,
  output logic     full,
  output logic     stackHit                        // A freed array is waiting
);

  typedef logic [`HEAP_ARRAY_BITS:0] count_t;

  logic [`HEAP_ARRAYS-1:0] allocBits;
  count_t                  mark;                   // Arrays handed out so far
  count_t                  stackTop;
  arrayId_t                freeStack [`HEAP_ARRAYS];
  logic                    clearAll;

  assign clearAll  = allocate && releaseArray;     // Heap reset request
  assign stackHit  = (stackTop != '0);
  assign granted   = stackHit ? freeStack[arrayId_t'(stackTop - count_t'(1))]
                              : arrayId_t'(mark);
  assign full      = !stackHit && (mark == count_t'(`HEAP_ARRAYS));
  assign known     = count_t'(arrayId) < mark;
  assign allocated = allocBits[arrayId];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits <= '0;
      mark      <= '0;
      stackTop  <= '0;
    end else if (clearAll) begin
      allocBits <= '0;
      mark      <= '0;
      stackTop  <= '0;
    end else if (allocate) begin
      allocBits[granted] <= 1'b1;
      if (stackHit) stackTop <= stackTop - count_t'(1);  // Reuse freed array first
      else mark <= mark + count_t'(1);
    end else if (releaseArray) begin
      allocBits[arrayId] <= 1'b0;
      stackTop           <= stackTop + count_t'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (releaseArray && !allocate) begin
      freeStack[arrayId_t'(stackTop)] <= arrayId;
    end
  end

endmodule

// ==== hdl/arrayStore.sv ====
//--------------------------------------
// Array store
// Element memory and one size register per array
//--------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module arrayStore import heapPkg::*; (
  input logic   clock,
  input logic   resetN,
  storeBus.store store
);

  data_t memory [`HEAP_ARRAYS][`HEAP_LENGTH];      // Fixed block per array
  size_t sizes  [`HEAP_ARRAYS];

  // Combinational reads of the addressed array
  assign store.readData = memory[store.arrayId][store.index];
  assign store.size     = sizes[store.arrayId];

  //--------------------------------------
  // Element write
  //--------------------------------------
  always_ff @(posedge clock) begin
    if (store.writeEnable) begin
      memory[store.arrayId][store.index] <= store.writeData;
    end
  end

  //--------------------------------------
  // Size registers
  //--------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;                            // All arrays empty
      end
    end else if (store.sizeWrite) begin
      sizes[store.arrayId] <= store.newSize;
    end
  end

endmodule

// ==== hdl/scanCounter.sv ====
//--------------------------------------
// Scan counter
// Steps an element index once per cycle
//--------------------------------------
`timescale 1ns/100ps

module scanCounter import heapPkg::*; (
  input  logic   clock,
  input  logic   resetN,
  input  logic   scanStart,
  input  size_t  limit,                            // Elements to visit
  output index_t scanIndex,
  output logic   scanLast
);

  logic running;

  // Empty array ends the scan in the start cycle
  assign scanLast = running ? (size_t'(scanIndex) == limit - size_t'(1))
                            : (scanStart && limit == '0);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      running   <= 1'b0;
      scanIndex <= '0;
    end else if (scanStart) begin
      running   <= (limit != '0);
      scanIndex <= '0;
    end else if (running) begin
      running <= !scanLast;
      if (!scanLast) begin
        scanIndex <= scanIndex + index_t'(1);
      end
    end
  end

endmodule

// ==== hdl/heapControl.sv ====
//--------------------------------------
// Heap control
// Latches, checks and sequences each request
// and answers with a one-cycle done
//--------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module heapControl import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        start,
  input  heapAction_t action,
  input  arrayId_t    arrayId,
  input  index_t      index,
  input  data_t       operand,
  output logic        done,
  output data_t       result,
  output heapError_t  error,
  output logic        allocate,
  output logic        releaseArray,
  input  arrayId_t    granted,
  input  logic        allocated,
  input  logic        known,
  input  logic        full,
  input  logic        stackHit,
  output logic        scanStart,
  output size_t       limit,
  input  index_t      scanIndex,
  input  logic        scanLast,
  output aluOp_t      op,
  output data_t       element,
  output data_t       operandOut,
  input  data_t       newValue,
  storeBus.control    store
);

  typedef enum logic [2:0] {stIdle, stCheck, stExecute, stScan, stRespond} state_t;

  state_t      state;
  heapAction_t reqAction;
  arrayId_t    reqArray;
  index_t      reqIndex;
  data_t       reqOperand;
  heapError_t  errorReg;
  heapError_t  checkError;
  data_t       count;                              // Scan accumulator
  data_t       execResult;
  index_t      targetIndex;
  logic        inBounds;
  logic        isScan;
  logic        isAfter;

  assign isScan   = reqAction inside {actIndex, actLess, actGreater};
  assign isAfter  = reqAction inside {actAddAfter, actSubAfter};
  assign inBounds = size_t'(reqIndex) < store.size;

  // Push writes past the end, pop reads the last element
  always_comb begin
    case (reqAction)
      actPush: targetIndex = index_t'(store.size);
      actPop:  targetIndex = index_t'(store.size - size_t'(1));
      default: targetIndex = reqIndex;
    endcase
  end

  // Request validation
  always_comb begin
    checkError = errNone;
    if (reqAction == actAlloc) begin
      if (full && !stackHit) checkError = errOutOfMemory;  // Nothing freed and nothing left
    end else if (reqAction != actReset) begin
      if (!known) checkError = errNotAllocated;
      else if (!allocated) checkError = (reqAction == actFree) ? errDoubleFree : errFreed;
      else begin
        case (reqAction)
          actRead, actAdd, actAddAfter, actSub, actSubAfter, actShiftLeft,
          actShiftRight, actNotLogical, actNot, actOr, actXor, actAnd:
            if (!inBounds) checkError = errBounds;
          actInc, actPush:
            if (store.size == `HEAP_LENGTH) checkError = errFull;
          actDec, actPop:
            if (store.size == '0) checkError = errEmpty;
          actResize:
            if (reqOperand > `HEAP_LENGTH) checkError = errTooLarge;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (reqAction)
      actAdd, actAddAfter: op = aluAdd;
      actSub, actSubAfter: op = aluSub;
      actShiftLeft:        op = aluShl;
      actShiftRight:       op = aluShr;
      actNotLogical:       op = aluNotLogical;
      actNot:              op = aluNot;
      actOr:               op = aluOr;
      actXor:              op = aluXor;
      actAnd:              op = aluAnd;
      actIndex:            op = aluEqual;
      actLess:             op = aluLess;
      actGreater:          op = aluGreater;
      default:             op = aluPass;         // Write and push store the operand
    endcase
  end

  assign element    = store.readData;
  assign operandOut = reqOperand;

  // Storage, allocator and result in the execute cycle
  always_comb begin
    store.arrayId     = (reqAction == actAlloc) ? granted : reqArray;
    store.index       = (state == stScan) ? scanIndex : targetIndex;
    store.writeData   = newValue;
    store.writeEnable = 1'b0;
    store.sizeWrite   = 1'b0;
    store.newSize     = store.size;
    allocate          = 1'b0;
    releaseArray      = 1'b0;
    execResult        = '0;
    if (state == stExecute && errorReg == errNone) begin
      case (reqAction)
        actReset: begin
          allocate     = 1'b1;                     // Both together empty the allocator
          releaseArray = 1'b1;
        end
        actWrite: begin
          store.writeEnable = 1'b1;
          store.sizeWrite   = !inBounds;           // Grow to cover the index
          store.newSize     = size_t'(reqIndex) + size_t'(1);
          execResult        = reqOperand;
        end
        actRead: execResult = store.readData;
        actSize: execResult = data_t'(store.size);
        actInc, actPush: begin
          store.writeEnable = (reqAction == actPush);
          store.sizeWrite   = 1'b1;
          store.newSize     = store.size + size_t'(1);
          execResult        = (reqAction == actPush) ? reqOperand : data_t'(store.newSize);
        end
        actDec, actPop: begin
          store.sizeWrite = 1'b1;
          store.newSize   = store.size - size_t'(1);
          execResult      = (reqAction == actPop) ? store.readData : data_t'(store.newSize);
        end
        actResize: begin
          store.sizeWrite = 1'b1;
          store.newSize   = size_t'(reqOperand);
          execResult      = reqOperand;
        end
        actAlloc: begin
          allocate        = 1'b1;
          store.sizeWrite = 1'b1;                  // New arrays start empty
          store.newSize   = '0;
          execResult      = data_t'(granted);
        end
        actFree: begin
          releaseArray = 1'b1;
          execResult   = data_t'(reqArray);
        end
        actAdd, actAddAfter, actSub, actSubAfter, actShiftLeft, actShiftRight,
        actNotLogical, actNot, actOr, actXor, actAnd: begin
          store.writeEnable = 1'b1;
          execResult        = isAfter ? store.readData : newValue;
        end
        default: ;
      endcase
    end
  end

  assign scanStart = (state == stCheck) && (checkError == errNone) && isScan;
  assign limit     = store.size;
  assign done      = (state == stExecute) || (state == stRespond);
  assign result    = (state == stRespond) ? count : execResult;
  assign error     = errorReg;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state     <= stIdle;
      reqAction <= actReset;
      errorReg  <= errNone;
      count     <= '0;
    end else begin
      case (state)
        stIdle: begin
          if (start) begin
            state     <= stCheck;
            reqAction <= action;
          end
        end
        stCheck: begin
          errorReg <= checkError;
          count    <= '0;
          if (checkError == errNone && isScan) state <= scanLast ? stRespond : stScan;
          else state <= stExecute;
        end
        stScan: begin
          if (newValue[0]) begin
            if (reqAction == actIndex) count <= data_t'(scanIndex) + data_t'(1);
            else count <= count + data_t'(1);
          end
          if (scanLast) state <= stRespond;
        end
        default: state <= stIdle;                  // Execute and respond last one cycle
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stIdle && start) begin
      reqArray   <= arrayId;
      reqIndex   <= index;
      reqOperand <= operand;
    end
  end

endmodule

// ==== hdl/storeBus.sv ====
//--------------------------------------
// Storage bus
// Element and size access between control and array store
//--------------------------------------
`timescale 1ns/100ps

interface storeBus import heapPkg::*; ();

  arrayId_t arrayId;                               // Addressed array
  index_t   index;                                 // Addressed element
  data_t    writeData;
  logic     writeEnable;
  logic     sizeWrite;                             // Load newSize into the array size
  size_t    newSize;
  data_t    readData;                              // Combinational element read
  size_t    size;                                  // Combinational size read

  modport control (
    output arrayId, index, writeData, writeEnable, sizeWrite, newSize,
    input  readData, size
  );

  modport store (
    input  arrayId, index, writeData, writeEnable, sizeWrite, newSize,
    output readData, size
  );

endinterface

// ==== hdl/heapPkg.sv ====
//--------------------------------------
// Heap types
// Actions, error codes, element operations and word widths
//--------------------------------------
`include "heap_config.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayId_t;  // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] index_t;    // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   size_t;     // Array size from 0 to length
  typedef logic [`HEAP_DATA_BITS-1:0]  data_t;     // Element word

  // Host request codes
  typedef enum logic [7:0] {
    actReset      = 8'd1,  actWrite    = 8'd2,  actRead       = 8'd3,
    actSize       = 8'd4,  actInc      = 8'd5,  actDec        = 8'd6,
    actIndex      = 8'd7,  actLess     = 8'd8,  actGreater    = 8'd9,
    actPush       = 8'd14, actPop      = 8'd15, actResize     = 8'd17,
    actAlloc      = 8'd18, actFree     = 8'd19, actAdd        = 8'd20,
    actAddAfter   = 8'd21, actSub      = 8'd22, actSubAfter   = 8'd23,
    actShiftLeft  = 8'd24, actShiftRight = 8'd25, actNotLogical = 8'd26,
    actNot        = 8'd27, actOr       = 8'd28, actXor        = 8'd29,
    actAnd        = 8'd30
  } heapAction_t;

  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,                        // Above the high-water mark
    errFreed        = 4'd2,
    errBounds       = 4'd3,
    errFull         = 4'd4,
    errEmpty        = 4'd5,
    errTooLarge     = 4'd6,
    errOutOfMemory  = 4'd7,
    errDoubleFree   = 4'd8
  } heapError_t;

  // Comparison ops put their match in bit 0
  typedef enum logic [3:0] {
    aluPass, aluAdd, aluSub, aluShl, aluShr, aluNotLogical, aluNot,
    aluOr, aluXor, aluAnd, aluEqual, aluLess, aluGreater
  } aluOp_t;

endpackage

// ==== hdl/heap_config.svh ====
//--------------------------------------
// Heap sizing
// Array count, array length and element width
//--------------------------------------
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

`define HEAP_ARRAY_BITS 3                          // 8 arrays
`define HEAP_INDEX_BITS 3                          // 8 elements per array
`define HEAP_DATA_BITS  16                         // Element width

// Derived sizes
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)

`endif
